//--- flist.f
+incdir+design
design/cnn_data_pkg.sv
design/cnn_ctrl_pkg.sv
design/conv_window_mac.sv
design/conv_frame_loader.sv
design/conv_engine.sv
design/conv_result_stage.sv
design/cnn_conv_top.sv
dv/cnn_conv_properties.sv
dv/cnn_conv_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the convolution testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f flist.f \
    --top-module cnn_conv_tb \
    --Mdir obj_dir -o cnn_conv_sim

# A failing assertion may stop the run early, so the log decides the outcome.
./obj_dir/cnn_conv_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "TEST OK" sim.log; then
    exit 0
fi
echo "Simulation did not pass, see sim.log."
exit 1

//--- dv/cnn_conv_tb.sv
`include "cnn_macros.svh"

module cnn_conv_tb;

    import cnn_data_pkg::*;
    import cnn_ctrl_pkg::*;

    localparam int OD = `CNN_OUT_DIM;
    localparam int MAP_LEN = OD * OD;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
    // Seven frames are sent and none of them takes 300 cycles, even under random back-pressure.
    localparam int MAX_CYCLES = 4000;

    logic       clk;
    logic       rst_n;
    logic       in_valid;
    logic       in_ready;
    in_beat_t   in_beat;
    logic       out_valid;
    logic       out_ready;
    feat_beat_t out_beat;

    pixel_t      tb_pix [`CNN_NUM_PIX];
    weight_t     tb_wgt [`CNN_NUM_WGT];
    feat_beat_t  exp_q [$];
    feat_beat_t  got_q [$];
    logic [31:0] lfsr_state = 32'ha013_5741;
    logic        ready_random;
    int          cycle_cnt;
    int          feat_errs;
    int          last_errs;
    int          ctrl_errs;
    int          count_errs;

    cnn_conv_top i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_beat   (in_beat),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_beat  (out_beat)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles.", MAX_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ####################
    // Random source.
    // ####################
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // The ready pattern is driven after the edge and transfers are sampled mid-cycle.
    always @(posedge clk) begin
        #2;
        if (ready_random) begin
            out_ready = rand_bits(1) != 0;
        end else begin
            out_ready = 1'b1;
        end
    end

    always @(negedge clk) begin
        if (rst_n && out_valid && out_ready) begin
            got_q.push_back(out_beat);
        end
    end

    // ####################
    // Reference model.
    // ####################
    task automatic model_feature(input int sum, output feature_t feat);
        if (sum < 0) begin
            feat = '0;
        end else if ((sum >>> `CNN_OUT_SHIFT) > 255) begin
            feat = 8'd255;
        end else begin
            feat = feature_t'(sum >>> `CNN_OUT_SHIFT);
        end
    endtask

    task automatic push_expected();
        feat_beat_t b;
        int         sum;
        for (int r = 0; r < OD; r++) begin
            for (int c = 0; c < OD; c++) begin
                for (int f = 0; f < `CNN_NUM_FILT; f++) begin
                    sum = 0;
                    for (int i = 0; i < `CNN_K_DIM; i++) begin
                        for (int j = 0; j < `CNN_K_DIM; j++) begin
                            sum += int'(tb_pix[(r + i) * `CNN_IMG_DIM + c + j])
                                 * int'(tb_wgt[f * 9 + i * `CNN_K_DIM + j]);
                        end
                    end
                    model_feature(sum, b.feat[f]);
                end
                b.last = (r == OD - 1) && (c == OD - 1);
                exp_q.push_back(b);
            end
        end
    endtask

    // ####################
    // Compare tasks.
    // ####################
    task automatic check_feature(input feature_t got, input feature_t want, input string what);
        if (got !== want) begin
            feat_errs++;
            $display("FAIL @%0t: %s feature is %0d, expected %0d", $time, what, got, want);
        end
    endtask

    task automatic check_last(input bit got, input bit want, input string what);
        if (got !== want) begin
            last_errs++;
            $display("FAIL @%0t: %s last is %0b, expected %0b", $time, what, got, want);
        end
    endtask

    task automatic check_ctrl(input logic got, input logic want, input string what);
        if (got !== want) begin
            ctrl_errs++;
            $display("FAIL @%0t: %s is %0b, expected %0b", $time, what, got, want);
        end
    endtask

    task automatic compare_outputs(input int n, input string tag);
        feat_beat_t got;
        feat_beat_t want;
        while (got_q.size() < n) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk); // Extra beats would show up here.
        if (got_q.size() != n) begin
            count_errs++;
            $display("FAIL @%0t: %s got %0d outputs, expected %0d", $time, tag, got_q.size(), n);
        end
        for (int k = 0; k < n && got_q.size() > 0; k++) begin
            got  = got_q.pop_front();
            want = exp_q.pop_front();
            for (int f = 0; f < `CNN_NUM_FILT; f++) begin
                check_feature(got.feat[f], want.feat[f],
                              $sformatf("%s beat %0d filter %0d", tag, k, f));
            end
            check_last(got.last, want.last, $sformatf("%s beat %0d", tag, k));
        end
        got_q.delete();
        exp_q.delete();
    endtask

    // ####################
    // Stimulus.
    // ####################
    task automatic send_beat(input beat_kind_e kind, input logic [7:0] data);
        logic ready_seen;
        in_beat.kind = kind;
        in_beat.data = data;
        in_valid     = 1'b1;
        do begin
            ready_seen = in_ready;
            @(posedge clk);
            #2;
        end while (!ready_seen);
        in_valid = 1'b0;
    endtask

    task automatic send_weights();
        @(posedge clk);
        #2;
        for (int i = 0; i < `CNN_NUM_WGT; i++) begin
            send_beat(BEAT_WEIGHT, tb_wgt[i]);
        end
    endtask

    task automatic send_frame();
        push_expected(); // Weights in tb_wgt are the ones the engine will copy.
        @(posedge clk);
        #2;
        for (int i = 0; i < `CNN_NUM_PIX; i++) begin
            send_beat(BEAT_PIXEL, tb_pix[i]);
        end
    endtask

    task automatic randomize_weights();
        for (int i = 0; i < `CNN_NUM_WGT; i++) begin
            tb_wgt[i] = weight_t'(rand_bits(8));
        end
    endtask

    task automatic randomize_frame();
        for (int i = 0; i < `CNN_NUM_PIX; i++) begin
            tb_pix[i] = pixel_t'(rand_bits(8));
        end
    endtask

    // ####################
    // Directed tests.
    // ####################
    task automatic test_single_frame();
        check_ctrl(out_valid, 1'b0, "out_valid after reset");
        check_ctrl(in_ready, 1'b1, "in_ready after reset");
        randomize_weights();
        randomize_frame();
        send_weights();
        send_frame();
        compare_outputs(MAP_LEN, "single frame");
    endtask

    task automatic test_backpressure();
        ready_random = 1'b1;
        send_frame();
        compare_outputs(MAP_LEN, "back-pressure");
        ready_random = 1'b0;
    endtask

    task automatic test_back_to_back();
        randomize_frame();
        send_frame();
        randomize_frame();
        send_frame();
        compare_outputs(2 * MAP_LEN, "back to back");
    endtask

    task automatic test_weight_reload();
        randomize_frame();
        send_frame();
        randomize_weights();
        send_weights();
        randomize_frame();
        send_frame();
        compare_outputs(2 * MAP_LEN, "weight reload");
    endtask

    task automatic test_extremes();
        for (int i = 0; i < 9; i++) begin
            tb_wgt[i]      = 8'sd127;
            tb_wgt[9 + i]  = -8'sd128;
            tb_wgt[18 + i] = (i == 4) ? 8'sd16 : 8'sd0; // Centre tap only.
        end
        for (int i = 0; i < `CNN_NUM_PIX; i++) begin
            tb_pix[i] = 8'd255;
        end
        send_weights();
        send_frame();
        compare_outputs(MAP_LEN, "extremes");
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        in_beat      = '0;
        out_ready    = 1'b0;
        ready_random = 1'b0;
        cycle_cnt    = 0;
        feat_errs    = 0;
        last_errs    = 0;
        ctrl_errs    = 0;
        count_errs   = 0;
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;

        test_single_frame();
        test_backpressure();
        test_back_to_back();
        test_weight_reload();
        test_extremes();

        $display("Errors: %0d feature, %0d last, %0d control, %0d count",
                 feat_errs, last_errs, ctrl_errs, count_errs);
        if (feat_errs + last_errs + ctrl_errs + count_errs == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- dv/cnn_conv_properties.sv
`include "cnn_macros.svh"

module cnn_conv_properties (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     in_valid,
    input logic                     in_ready,
    input cnn_ctrl_pkg::in_beat_t   in_beat,
    input logic                     frame_valid,
    input logic                     frame_ready,
    input cnn_ctrl_pkg::frame_t     frame,
    input logic                     conv_valid,
    input logic                     conv_ready,
    input cnn_ctrl_pkg::conv_beat_t conv_beat,
    input logic                     out_valid,
    input logic                     out_ready,
    input cnn_ctrl_pkg::feat_beat_t out_beat
);

    localparam int MAP_LEN = `CNN_OUT_DIM * `CNN_OUT_DIM;

    int unsigned out_cnt; // Output transfers within the current map.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_cnt <= 0;
        end else if (out_valid && out_ready) begin
            out_cnt <= (out_cnt == MAP_LEN - 1) ? 0 : out_cnt + 1;
        end
    end

    // ####################
    // Stability under stall on every link.
    // ####################
    assert property (@(posedge clk) disable iff (!rst_n)
        in_valid && !in_ready |=> in_valid && $stable(in_beat))
        else $error("Input beat dropped or changed while stalled.");

    assert property (@(posedge clk) disable iff (!rst_n)
        frame_valid && !frame_ready |=> frame_valid && $stable(frame))
        else $error("Frame offer dropped or changed while stalled.");

    assert property (@(posedge clk) disable iff (!rst_n)
        conv_valid && !conv_ready |=> conv_valid && $stable(conv_beat))
        else $error("Window sum dropped or changed while stalled.");

    assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_beat))
        else $error("Output beat dropped or changed while stalled.");

    // ####################
    // Reset state and map framing.
    // ####################
    assert property (@(posedge clk) $rose(rst_n) |-> !frame_valid && !conv_valid && !out_valid)
        else $error("A valid signal is high right after reset.");

    assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && out_ready |-> out_beat.last == (out_cnt == MAP_LEN - 1))
        else $error("Last flag is not on every 36th output transfer.");

endmodule

bind cnn_conv_top cnn_conv_properties i_props (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .in_beat     (in_beat),
    .frame_valid (frame_valid),
    .frame_ready (frame_ready),
    .frame       (frame),
    .conv_valid  (conv_valid),
    .conv_ready  (conv_ready),
    .conv_beat   (conv_beat),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_beat    (out_beat)
);

//--- design/cnn_conv_top.sv
module cnn_conv_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  cnn_ctrl_pkg::in_beat_t   in_beat,
    output logic                     out_valid,
    input  logic                     out_ready,
    output cnn_ctrl_pkg::feat_beat_t out_beat
);

    import cnn_ctrl_pkg::*;

    // Loader to engine.
    logic       frame_valid;
    logic       frame_ready;
    frame_t     frame;

    // Engine to result stage.
    logic       conv_valid;
    logic       conv_ready;
    conv_beat_t conv_beat;

    conv_frame_loader i_loader (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_beat     (in_beat),
        .frame_valid (frame_valid),
        .frame_ready (frame_ready),
        .frame       (frame)
    );

    conv_engine i_engine (
        .clk         (clk),
        .rst_n       (rst_n),
        .frame_valid (frame_valid),
        .frame_ready (frame_ready),
        .frame       (frame),
        .conv_valid  (conv_valid),
        .conv_ready  (conv_ready),
        .conv_beat   (conv_beat)
    );

    conv_result_stage i_result (
        .clk        (clk),
        .rst_n      (rst_n),
        .conv_valid (conv_valid),
        .conv_ready (conv_ready),
        .conv_beat  (conv_beat),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_beat   (out_beat)
    );

endmodule

//--- design/conv_result_stage.sv
`include "cnn_macros.svh"

module conv_result_stage (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     conv_valid,
    output logic                     conv_ready,
    input  cnn_ctrl_pkg::conv_beat_t conv_beat,
    output logic                     out_valid,
    input  logic                     out_ready,
    output cnn_ctrl_pkg::feat_beat_t out_beat
);

    import cnn_data_pkg::*;
    import cnn_ctrl_pkg::*;

    localparam int FEAT_MAX = (1 << `CNN_PIX_W) - 1;

    feat_beat_t next_beat;
    logic       conv_fire;

    // ReLU, then scale down, then clamp into the output byte.
    function automatic feature_t to_feature(input acc_t value);
        acc_t scaled;
        scaled = value >>> `CNN_OUT_SHIFT;
        if (value < 0) begin
            return '0;
        end else if (scaled > acc_t'(FEAT_MAX)) begin
            return feature_t'(FEAT_MAX);
        end
        return feature_t'(scaled);
    endfunction

    always_comb begin
        for (int f = 0; f < `CNN_NUM_FILT; f++) begin
            next_beat.feat[f] = to_feature(conv_beat.acc[f]);
        end
        next_beat.last = conv_beat.last;
    end

    // ####################
    // Output register.
    // ####################
    assign conv_ready = !out_valid || out_ready; // Refill on the edge that drains.
    assign conv_fire  = conv_valid && conv_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (conv_fire) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (conv_fire) begin
            out_beat <= next_beat;
        end
    end

endmodule

//--- design/conv_engine.sv
`include "cnn_macros.svh"

module conv_engine (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     frame_valid,
    output logic                     frame_ready,
    input  cnn_ctrl_pkg::frame_t     frame,
    output logic                     conv_valid,
    input  logic                     conv_ready,
    output cnn_ctrl_pkg::conv_beat_t conv_beat
);

    import cnn_data_pkg::*;
    import cnn_ctrl_pkg::*;

    localparam int KSIZE = `CNN_K_DIM * `CNN_K_DIM;
    localparam int POS_W = $clog2(`CNN_OUT_DIM);

    engine_state_e          state;
    frame_t                 frame_q;
    logic [POS_W-1:0]       row;
    logic [POS_W-1:0]       col;
    pixel_t [KSIZE-1:0]     window;
    acc_vec_t               sums;

    logic frame_fire;
    logic conv_fire;
    logic issue;
    logic last_pos;

    assign frame_ready = (state == ENG_IDLE);
    assign frame_fire  = frame_valid && frame_ready;
    assign conv_fire   = conv_valid && conv_ready;
    assign last_pos    = (row == POS_W'(`CNN_OUT_DIM - 1)) && (col == POS_W'(`CNN_OUT_DIM - 1));

    // A new position is loaded when the output register is free or drains now.
    // Nothing is loaded behind the last position of the map.
    assign issue = (state == ENG_SCAN) && (!conv_valid || (conv_ready && !conv_beat.last));

    always_ff @(posedge clk) begin
        if (frame_fire) begin
            frame_q <= frame;
        end
    end

    // ####################
    // Window select and MACs.
    // ####################
    always_comb begin
        for (int i = 0; i < `CNN_K_DIM; i++) begin
            for (int j = 0; j < `CNN_K_DIM; j++) begin
                window[i*`CNN_K_DIM + j] = frame_q.pix[(row + i) * `CNN_IMG_DIM + col + j];
            end
        end
    end

    for (genvar f = 0; f < `CNN_NUM_FILT; f++) begin : g_mac
        conv_window_mac i_mac (
            .window (window),
            .kernel (frame_q.wgt[f*KSIZE +: KSIZE]),
            .sum    (sums[f])
        );
    end

    // ####################
    // Scan control.
    // ####################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ENG_IDLE;
            conv_valid <= 1'b0;
            row        <= '0;
            col        <= '0;
        end else begin
            if (frame_fire) begin
                state <= ENG_SCAN;
            end else if (conv_fire && conv_beat.last) begin
                state <= ENG_IDLE;
            end
            if (issue) begin
                conv_valid <= 1'b1;
            end else if (conv_fire) begin
                conv_valid <= 1'b0;
            end
            if (issue) begin
                if (col == POS_W'(`CNN_OUT_DIM - 1)) begin
                    col <= '0;
                    row <= last_pos ? '0 : row + 1'b1; // Counters are back at zero when idle.
                end else begin
                    col <= col + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            conv_beat.acc  <= sums;
            conv_beat.last <= last_pos;
        end
    end

endmodule

//--- design/conv_frame_loader.sv
`include "cnn_macros.svh"

module conv_frame_loader (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  cnn_ctrl_pkg::in_beat_t in_beat,
    output logic                  frame_valid,
    input  logic                  frame_ready,
    output cnn_ctrl_pkg::frame_t  frame
);

    import cnn_data_pkg::*;
    import cnn_ctrl_pkg::*;

    localparam int PIX_IDX_W = $clog2(`CNN_NUM_PIX);
    localparam int WGT_IDX_W = $clog2(`CNN_NUM_WGT);

    pixel_t  [`CNN_NUM_PIX-1:0] pix_buf;
    weight_t [`CNN_NUM_WGT-1:0] wgt_bank;
    logic    [PIX_IDX_W-1:0]    pix_idx;
    logic    [WGT_IDX_W-1:0]    wgt_idx;

    logic in_fire;
    logic pix_fire;
    logic wgt_fire;

    // Loading stalls while a complete frame waits for the engine.
    assign in_ready = !frame_valid;
    assign in_fire  = in_valid && in_ready;
    assign pix_fire = in_fire && (in_beat.kind == BEAT_PIXEL);
    assign wgt_fire = in_fire && (in_beat.kind == BEAT_WEIGHT);

    // ####################
    // Index and weight bank.
    // ####################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pix_idx  <= '0;
            wgt_idx  <= '0;
            wgt_bank <= '0;
        end else begin
            if (pix_fire) begin
                pix_idx <= pix_idx + 1'b1; // Wraps naturally after 64 pixels.
            end
            if (wgt_fire) begin
                wgt_bank[wgt_idx] <= weight_t'(in_beat.data);
                if (wgt_idx == WGT_IDX_W'(`CNN_NUM_WGT - 1)) begin
                    wgt_idx <= '0;
                end else begin
                    wgt_idx <= wgt_idx + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pix_fire) begin
            pix_buf[pix_idx] <= pixel_t'(in_beat.data);
        end
    end

    // ####################
    // Frame hand-off.
    // ####################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frame_valid <= 1'b0;
        end else if (pix_fire && (pix_idx == PIX_IDX_W'(`CNN_NUM_PIX - 1))) begin
            frame_valid <= 1'b1;
        end else if (frame_ready) begin
            frame_valid <= 1'b0;
        end
    end

    // Both stores are frozen while frame_valid is high, so the offer stays stable.
    assign frame.pix = pix_buf;
    assign frame.wgt = wgt_bank;

endmodule

//--- design/conv_window_mac.sv
`include "cnn_macros.svh"

module conv_window_mac (
    input  cnn_data_pkg::pixel_t  [`CNN_K_DIM*`CNN_K_DIM-1:0] window,
    input  cnn_data_pkg::weight_t [`CNN_K_DIM*`CNN_K_DIM-1:0] kernel,
    output cnn_data_pkg::acc_t                                sum
);

    import cnn_data_pkg::*;

    localparam int KSIZE = `CNN_K_DIM * `CNN_K_DIM;

    acc_t prod [KSIZE];
    acc_t lvl1 [4];
    acc_t lvl2 [2];

    // Pixels are unsigned, so a zero is put in front before the signed multiply.
    always_comb begin
        for (int i = 0; i < KSIZE; i++) begin
            prod[i] = acc_t'(signed'({1'b0, window[i]})) * acc_t'(kernel[i]);
        end
    end

    // ####################
    // Adder tree.
    // ####################
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            lvl1[i] = prod[2*i] + prod[2*i+1];
        end
        for (int i = 0; i < 2; i++) begin
            lvl2[i] = lvl1[2*i] + lvl1[2*i+1];
        end
    end

    assign sum = lvl2[0] + lvl2[1] + prod[KSIZE-1]; // The ninth product joins last.

endmodule

//--- design/cnn_ctrl_pkg.sv
`include "cnn_macros.svh"

package cnn_ctrl_pkg;

    import cnn_data_pkg::*;

    // ####################
    // Input stream.
    // ####################
    typedef enum logic {
        BEAT_WEIGHT = 1'b0, // Next coefficient of the weight bank.
        BEAT_PIXEL  = 1'b1  // Next pixel of the frame in row-major order.
    } beat_kind_e;

    typedef struct packed {
        beat_kind_e            kind;
        logic [`CNN_PIX_W-1:0] data;
    } in_beat_t;

    // ####################
    // Internal links.
    // ####################

    // Weights are ordered filter, then row, then column.
    typedef struct packed {
        pixel_t  [`CNN_NUM_PIX-1:0] pix;
        weight_t [`CNN_NUM_WGT-1:0] wgt;
    } frame_t;

    typedef acc_t [`CNN_NUM_FILT-1:0] acc_vec_t; // One sum per filter.

    typedef struct packed {
        acc_vec_t acc;
        logic     last; // Set on the final window position of a map.
    } conv_beat_t;

    typedef struct packed {
        feature_t [`CNN_NUM_FILT-1:0] feat;
        logic                         last;
    } feat_beat_t;

    typedef enum logic {
        ENG_IDLE,
        ENG_SCAN
    } engine_state_e;

endpackage

//--- design/cnn_data_pkg.sv
`include "cnn_macros.svh"

package cnn_data_pkg;

    // ####################
    // Numeric types of the datapath.
    // ####################

    // Unsigned image sample as it arrives on the stream.
    typedef logic [`CNN_PIX_W-1:0] pixel_t;

    // Signed filter coefficient.
    typedef logic signed [`CNN_PIX_W-1:0] weight_t;

    // Window sum of nine products.
    // The worst case 9 * 255 * 128 needs 19 bits plus sign.
    typedef logic signed [`CNN_ACC_W-1:0] acc_t;

    // Rectified, scaled and saturated output value.
    typedef logic [`CNN_PIX_W-1:0] feature_t;

endpackage

//--- design/cnn_macros.svh
`ifndef CNN_MACROS_SVH
`define CNN_MACROS_SVH

// ####################
// Image and kernel geometry.
// ####################
`define CNN_IMG_DIM   8
`define CNN_K_DIM     3
`define CNN_OUT_DIM   (`CNN_IMG_DIM - `CNN_K_DIM + 1)
`define CNN_NUM_FILT  3

// ####################
// Data widths and scaling.
// ####################
`define CNN_PIX_W     8
`define CNN_ACC_W     20
`define CNN_OUT_SHIFT 4 // Right shift applied after ReLU.

`define CNN_NUM_PIX   (`CNN_IMG_DIM * `CNN_IMG_DIM)
`define CNN_NUM_WGT   (`CNN_NUM_FILT * `CNN_K_DIM * `CNN_K_DIM)

`endif
